// File: src/pico16_pkg.sv
//--------------------
// shared types and constants of the pico16 core
// every RTL block imports this package
//--------------------
`default_nettype none

package pico16_pkg;

  // datapath geometry
  localparam int WORD_W    = 16;
  localparam int REG_IDX_W = 3;
  localparam int NUM_REGS  = 8;
  localparam int IMM_W     = 6;

  // fixed program addresses
  localparam logic [WORD_W-1:0] RESET_PC = 16'h0000;
  localparam logic [WORD_W-1:0] INTR_VEC = 16'h0010;
  localparam logic [WORD_W-1:0] NMI_VEC  = 16'h0020;

  // instruction opcodes, bits 15..12 of the instruction word
  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_LDI  = 4'h1,
    OP_ADD  = 4'h2,
    OP_SUB  = 4'h3,
    OP_AND  = 4'h4,
    OP_XOR  = 4'h5,
    OP_LD   = 4'h6,
    OP_ST   = 4'h7,
    OP_BEQZ = 4'h8,
    OP_JMP  = 4'h9,
    OP_EI   = 4'hA,
    OP_DI   = 4'hB,
    OP_HLT  = 4'hC,
    OP_IRET = 4'hD
  } opcode_e;

  // sequencer phases
  typedef enum logic [2:0] {
    PH_FETCH = 3'd0,
    PH_EXEC  = 3'd1,
    PH_MEM   = 3'd2,
    PH_HALT  = 3'd3,
    PH_IRQ   = 3'd4
  } phase_e;

  // ALU functions
  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_AND = 2'd2,
    ALU_XOR = 2'd3
  } alu_op_e;

endpackage

`default_nettype wire

// File: src/pico16_fetch.sv
//--------------------
// instruction sequencer: phase machine, pc and instruction register
// all state holds while the memory raises block_i
//--------------------
`timescale 1ns/1ns
`default_nettype none

module pico16_fetch
  import pico16_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              block_i,
  input  logic [WORD_W-1:0] mem_dat_i,
  input  logic              take_irq_i,
  input  logic              take_nmi_i,
  input  logic              halt_i,
  input  logic              branch_taken_i,
  input  logic [WORD_W-1:0] branch_target_i,
  input  logic              is_mem_op_i,
  input  logic              is_hlt_i,
  input  logic              is_iret_i,
  input  logic [WORD_W-1:0] epc_i,
  output phase_e            phase_o,
  output logic [WORD_W-1:0] ir_o,
  output logic [WORD_W-1:0] pc_o,
  output logic [WORD_W-1:0] ret_pc_o
);

  phase_e            phase_q;
  phase_e            phase_d;
  logic [WORD_W-1:0] pc_q;
  logic [WORD_W-1:0] ir_q;
  logic [WORD_W-1:0] flow_pc;
  logic              nmi_entry_q;
  logic              take_any;

  assign take_any = take_irq_i | take_nmi_i;

  // where the program continues once the current instruction retires
  always_comb
  begin
    if (phase_q == PH_EXEC && branch_taken_i)
      flow_pc = branch_target_i;
    else if (phase_q == PH_EXEC && is_iret_i)
      flow_pc = epc_i;
    else
      flow_pc = pc_q;
  end

  always_comb
  begin
    phase_d = phase_q;
    case (phase_q)
      PH_FETCH: phase_d = PH_EXEC;
      PH_EXEC:
      begin
        if (is_mem_op_i)
          phase_d = PH_MEM;
        else if (is_hlt_i)
          phase_d = PH_HALT;
        else if (take_any)
          phase_d = PH_IRQ;
        else
          phase_d = PH_FETCH;
      end
      PH_MEM:  phase_d = take_any ? PH_IRQ : PH_FETCH;
      // halt without the latch set just falls through to fetch
      PH_HALT: phase_d = take_any ? PH_IRQ : (halt_i ? PH_HALT : PH_FETCH);
      PH_IRQ:  phase_d = PH_FETCH;
      default: phase_d = PH_FETCH;
    endcase
  end

  // parked in halt during reset so the first edge starts the fetch
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      phase_q     <= PH_HALT;
      pc_q        <= RESET_PC;
      ir_q        <= '0;
      nmi_entry_q <= 1'b0;
    end
    else if (!block_i)
    begin
      phase_q <= phase_d;
      case (phase_q)
        PH_FETCH:
        begin
          ir_q <= mem_dat_i;
          pc_q <= pc_q + WORD_W'(1);
        end
        PH_IRQ:  pc_q <= nmi_entry_q ? NMI_VEC : INTR_VEC;
        default: pc_q <= flow_pc;
      endcase
      if (take_any)
        nmi_entry_q <= take_nmi_i;
    end
  end

  assign phase_o  = phase_q;
  assign ir_o     = ir_q;
  assign pc_o     = pc_q;
  assign ret_pc_o = flow_pc;

  // an accepted interrupt always moves the sequencer into PH_IRQ
  assert property (@(posedge clk) disable iff (!rst)
    take_any |-> phase_d == PH_IRQ);

endmodule

`default_nettype wire

// File: src/pico16_decode.sv
//--------------------
// instruction decoder, purely combinational
// flags are only raised in the exec and mem phases
//--------------------
`timescale 1ns/1ns
`default_nettype none

module pico16_decode
  import pico16_pkg::*;
(
  input  logic [WORD_W-1:0]    ir_i,
  input  phase_e               phase_i,
  output opcode_e              op_o,
  output logic [REG_IDX_W-1:0] rd_o,
  output logic [REG_IDX_W-1:0] rs_o,
  output logic [WORD_W-1:0]    imm_o,
  output alu_op_e              alu_op_o,
  output logic                 is_mem_op_o,
  output logic                 is_hlt_o,
  output logic                 is_iret_o,
  output logic                 writes_reg_o
);

  logic [3:0]       opc_field;
  logic [IMM_W-1:0] imm_field;
  logic             in_exec;
  logic             in_mem;
  logic             is_alu;

  // opcode | rd | rs | imm
  assign opc_field = ir_i[15:12];
  assign rd_o      = ir_i[11:9];
  assign rs_o      = ir_i[8:6];
  assign imm_field = ir_i[IMM_W-1:0];
  assign imm_o     = {{(WORD_W-IMM_W){imm_field[IMM_W-1]}}, imm_field};

  // codes 14 and 15 are not defined
  always_comb
  begin
    case (opc_field)
      OP_NOP, OP_LDI, OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_LD, OP_ST,
      OP_BEQZ, OP_JMP, OP_EI, OP_DI, OP_HLT, OP_IRET:
        op_o = opcode_e'(opc_field);
      default:
        op_o = OP_NOP;
    endcase
  end

  // address forming ops (LD, ST, JMP) use the adder
  always_comb
  begin
    case (op_o)
      OP_SUB:  alu_op_o = ALU_SUB;
      OP_AND:  alu_op_o = ALU_AND;
      OP_XOR:  alu_op_o = ALU_XOR;
      default: alu_op_o = ALU_ADD;
    endcase
  end

  assign in_exec = (phase_i == PH_EXEC);
  assign in_mem  = (phase_i == PH_MEM);
  assign is_alu  = (op_o == OP_ADD) || (op_o == OP_SUB) ||
                   (op_o == OP_AND) || (op_o == OP_XOR);

  assign is_mem_op_o = (in_exec || in_mem) && (op_o == OP_LD || op_o == OP_ST);
  assign is_hlt_o    = (in_exec || in_mem) && (op_o == OP_HLT);
  assign is_iret_o   = (in_exec || in_mem) && (op_o == OP_IRET);

  // loads write back in the mem phase, the rest in exec
  assign writes_reg_o = (in_exec && (is_alu || op_o == OP_LDI)) ||
                        (in_mem && op_o == OP_LD);

endmodule

`default_nettype wire

// File: src/pico16_execute.sv
//--------------------
// register file, ALU, branch evaluation and interrupt flag
// writes arrive from the result block already stall qualified
//--------------------
`timescale 1ns/1ns
`default_nettype none

module pico16_execute
  import pico16_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  opcode_e              op_i,
  input  logic [REG_IDX_W-1:0] rd_i,
  input  logic [REG_IDX_W-1:0] rs_i,
  input  logic [WORD_W-1:0]    imm_i,
  input  alu_op_e              alu_op_i,
  input  phase_e               phase_i,
  input  logic [WORD_W-1:0]    pc_i,
  input  logic                 wr_en_i,
  input  logic [REG_IDX_W-1:0] wr_idx_i,
  input  logic [WORD_W-1:0]    wr_data_i,
  input  logic                 ifl_set_i,
  input  logic                 ifl_clr_i,
  output logic [WORD_W-1:0]    rd_val_o,
  output logic [WORD_W-1:0]    rs_val_o,
  output logic [WORD_W-1:0]    alu_o,
  output logic                 zero_o,
  output logic                 branch_taken_o,
  output logic [WORD_W-1:0]    branch_target_o,
  output logic                 ifl_o
);

  logic [WORD_W-1:0] regs [NUM_REGS];
  logic [WORD_W-1:0] opa;
  logic [WORD_W-1:0] opb;
  logic              addr_form;
  logic              ifl_q;

  // r0 is an ordinary register
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wr_en_i)
      regs[wr_idx_i] <= wr_data_i;
  end

  assign rd_val_o = regs[rd_i];
  assign rs_val_o = regs[rs_i];

  // LD, ST and JMP compute rs + imm on the same adder
  assign addr_form = (op_i == OP_LD) || (op_i == OP_ST) || (op_i == OP_JMP);
  assign opa       = addr_form ? rs_val_o : rd_val_o;
  assign opb       = addr_form ? imm_i : rs_val_o;

  always_comb
  begin
    case (alu_op_i)
      ALU_ADD: alu_o = opa + opb;
      ALU_SUB: alu_o = opa - opb;
      ALU_AND: alu_o = opa & opb;
      default: alu_o = opa ^ opb;
    endcase
  end

  assign zero_o = (rd_val_o == '0);

  // pc already points past the branch when this is evaluated
  assign branch_taken_o  = (phase_i == PH_EXEC) &&
                           ((op_i == OP_BEQZ && zero_o) || op_i == OP_JMP);
  assign branch_target_o = (op_i == OP_JMP) ? alu_o : pc_i + imm_i;

  // interrupt enable
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      ifl_q <= 1'b0;
    else if (ifl_clr_i)
      ifl_q <= 1'b0;
    else if (ifl_set_i)
      ifl_q <= 1'b1;
  end

  assign ifl_o = ifl_q;

endmodule

`default_nettype wire

// File: src/pico16_result.sv
//--------------------
// load/store staging for the mem phase and register writeback select
//--------------------
`timescale 1ns/1ns
`default_nettype none

module pico16_result
  import pico16_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  phase_e               phase_i,
  input  logic                 block_i,
  input  opcode_e              op_i,
  input  logic                 writes_reg_i,
  input  logic [REG_IDX_W-1:0] rd_i,
  input  logic [WORD_W-1:0]    alu_i,
  input  logic [WORD_W-1:0]    rd_val_i,
  input  logic [WORD_W-1:0]    rs_val_i,
  input  logic [WORD_W-1:0]    imm_i,
  input  logic [WORD_W-1:0]    mem_dat_i,
  output logic [WORD_W-1:0]    mem_adr_o,
  output logic [WORD_W-1:0]    mem_dat_o,
  output logic                 mem_we_o,
  output logic                 wr_en_o,
  output logic [REG_IDX_W-1:0] wr_idx_o,
  output logic [WORD_W-1:0]    wr_data_o
);

  logic [WORD_W-1:0] adr_q;
  logic [WORD_W-1:0] dat_q;
  logic              we_q;
  logic              stage;

  assign stage = !block_i && (phase_i == PH_EXEC);

  // address and store data captured at the end of exec
  always_ff @(posedge clk)
  begin
    if (stage)
    begin
      adr_q <= alu_i;
      dat_q <= rd_val_i;
    end
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      we_q <= 1'b0;
    else if (stage)
      we_q <= (op_i == OP_ST);
    else if (!block_i && phase_i == PH_MEM)
      we_q <= 1'b0;
  end

  assign mem_adr_o = adr_q;
  assign mem_dat_o = dat_q;
  assign mem_we_o  = we_q;

  assign wr_en_o   = writes_reg_i && !block_i;
  assign wr_idx_o  = rd_i;
  assign wr_data_o = (phase_i == PH_MEM) ? mem_dat_i :
                     (op_i == OP_LDI) ? imm_i : alu_i;

  assert property (@(posedge clk) disable iff (!rst)
    $rose(mem_we_o) |-> phase_i == PH_MEM && op_i == OP_ST);

  // execute's adder must hand over rs + imm for memory ops
  assert property (@(posedge clk) disable iff (!rst)
    stage && (op_i == OP_LD || op_i == OP_ST) |-> alu_i == rs_val_i + imm_i);

endmodule

`default_nettype wire

// File: src/pico16_irq.sv
//--------------------
// nmi edge capture, halt latch, arbitration and acknowledge pulses
//--------------------
`timescale 1ns/1ns
`default_nettype none

module pico16_irq
  import pico16_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   nmi_i,
  input  logic   intr_i,
  input  logic   ifl_i,
  input  phase_e phase_i,
  input  logic   at_boundary_i,
  input  logic   is_hlt_i,
  output logic   take_irq_o,
  output logic   take_nmi_o,
  output logic   halt_o,
  output logic   inta_o,
  output logic   nmia_o
);

  logic nmi_old_q;
  logic nmi_pend_q;
  logic halt_q;
  logic inta_q;
  logic nmia_q;

  // nmi wins over intr, which also needs the enable flag
  assign take_nmi_o = at_boundary_i && nmi_pend_q;
  assign take_irq_o = at_boundary_i && intr_i && ifl_i && !nmi_pend_q;

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      nmi_old_q  <= 1'b0;
      nmi_pend_q <= 1'b0;
      halt_q     <= 1'b0;
      inta_q     <= 1'b0;
      nmia_q     <= 1'b0;
    end
    else
    begin
      nmi_old_q <= nmi_i;
      // a level held high only arms once
      if (nmi_i && !nmi_old_q)
        nmi_pend_q <= 1'b1;
      else if (nmia_q)
        nmi_pend_q <= 1'b0;

      if (take_irq_o || take_nmi_o)
        halt_q <= 1'b0;
      else if (is_hlt_i && phase_i == PH_EXEC)
        halt_q <= 1'b1;

      // acks land in the entry cycle
      inta_q <= take_irq_o;
      nmia_q <= take_nmi_o;
    end
  end

  assign halt_o = halt_q;
  assign inta_o = inta_q;
  assign nmia_o = nmia_q;

  assert property (@(posedge clk) disable iff (!rst)
    (inta_o || nmia_o) |-> phase_i == PH_IRQ);

  assert property (@(posedge clk) disable iff (!rst)
    (inta_o || nmia_o) |=> !(inta_o || nmia_o));

endmodule

`default_nettype wire

// File: src/pico16_core.sv
//--------------------
// pico16 top: sequencer, datapath and interrupt logic on one memory bus
//--------------------
`timescale 1ns/1ns
`default_nettype none

module pico16_core
  import pico16_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [WORD_W-1:0] mem_dat_i,
  input  logic              block_i,
  input  logic              intr_i,
  input  logic              nmi_i,
  output logic [WORD_W-1:0] mem_adr_o,
  output logic [WORD_W-1:0] mem_dat_o,
  output logic              mem_we_o,
  output logic              mem_req_o,
  output logic              inta_o,
  output logic              nmia_o
);

  phase_e               phase;
  opcode_e              op;
  alu_op_e              alu_op;
  logic [WORD_W-1:0]    ir;
  logic [WORD_W-1:0]    pc;
  logic [WORD_W-1:0]    ret_pc;
  logic [WORD_W-1:0]    epc;
  logic [WORD_W-1:0]    imm;
  logic [WORD_W-1:0]    rd_val;
  logic [WORD_W-1:0]    rs_val;
  logic [WORD_W-1:0]    alu;
  logic [WORD_W-1:0]    branch_target;
  logic [WORD_W-1:0]    wr_data;
  logic [WORD_W-1:0]    res_adr;
  logic [REG_IDX_W-1:0] rd;
  logic [REG_IDX_W-1:0] rs;
  logic [REG_IDX_W-1:0] wr_idx;
  logic                 is_mem_op;
  logic                 is_hlt;
  logic                 is_iret;
  logic                 writes_reg;
  logic                 zero;
  logic                 branch_taken;
  logic                 ifl;
  logic                 ifl_set;
  logic                 ifl_clr;
  logic                 wr_en;
  logic                 take_irq;
  logic                 take_nmi;
  logic                 halt;
  logic                 at_boundary;

  pico16_fetch u_fetch (
    .clk(clk), .rst(rst), .block_i(block_i), .mem_dat_i(mem_dat_i),
    .take_irq_i(take_irq), .take_nmi_i(take_nmi), .halt_i(halt),
    .branch_taken_i(branch_taken), .branch_target_i(branch_target),
    .is_mem_op_i(is_mem_op), .is_hlt_i(is_hlt), .is_iret_i(is_iret), .epc_i(epc),
    .phase_o(phase), .ir_o(ir), .pc_o(pc), .ret_pc_o(ret_pc)
  );

  pico16_decode u_decode (
    .ir_i(ir), .phase_i(phase), .op_o(op), .rd_o(rd), .rs_o(rs), .imm_o(imm),
    .alu_op_o(alu_op), .is_mem_op_o(is_mem_op), .is_hlt_o(is_hlt),
    .is_iret_o(is_iret), .writes_reg_o(writes_reg)
  );

  pico16_execute u_execute (
    .clk(clk), .rst(rst), .op_i(op), .rd_i(rd), .rs_i(rs), .imm_i(imm),
    .alu_op_i(alu_op), .phase_i(phase), .pc_i(pc), .wr_en_i(wr_en),
    .wr_idx_i(wr_idx), .wr_data_i(wr_data), .ifl_set_i(ifl_set), .ifl_clr_i(ifl_clr),
    .rd_val_o(rd_val), .rs_val_o(rs_val), .alu_o(alu), .zero_o(zero),
    .branch_taken_o(branch_taken), .branch_target_o(branch_target), .ifl_o(ifl)
  );

  pico16_result u_result (
    .clk(clk), .rst(rst), .phase_i(phase), .block_i(block_i), .op_i(op),
    .writes_reg_i(writes_reg), .rd_i(rd), .alu_i(alu), .rd_val_i(rd_val),
    .rs_val_i(rs_val), .imm_i(imm), .mem_dat_i(mem_dat_i), .mem_adr_o(res_adr),
    .mem_dat_o(mem_dat_o), .mem_we_o(mem_we_o), .wr_en_o(wr_en), .wr_idx_o(wr_idx),
    .wr_data_o(wr_data)
  );

  pico16_irq u_irq (
    .clk(clk), .rst(rst), .nmi_i(nmi_i), .intr_i(intr_i), .ifl_i(ifl),
    .phase_i(phase), .at_boundary_i(at_boundary), .is_hlt_i(is_hlt),
    .take_irq_o(take_irq), .take_nmi_o(take_nmi), .halt_o(halt),
    .inta_o(inta_o), .nmia_o(nmia_o)
  );

  // instruction boundaries, never while the bus is stalled
  assign at_boundary = !block_i &&
                       ((phase == PH_EXEC && !is_mem_op && !is_hlt) ||
                        phase == PH_MEM || phase == PH_HALT);

  assign ifl_set = !block_i && phase == PH_EXEC && (op == OP_EI || is_iret);
  assign ifl_clr = !block_i && ((phase == PH_EXEC && op == OP_DI) || phase == PH_IRQ);

  // return address saved on interrupt entry
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      epc <= RESET_PC;
    else if (take_irq || take_nmi)
      epc <= ret_pc;
  end

  assign mem_adr_o = (phase == PH_MEM) ? res_adr : pc;
  assign mem_req_o = (phase == PH_FETCH) || (phase == PH_MEM);

  // a held request keeps the bus frozen until the memory lets go
  assert property (@(posedge clk) disable iff (!rst)
    mem_req_o && block_i |=> mem_req_o && $stable(mem_adr_o) && $stable(mem_we_o) &&
                             (!mem_we_o || $stable(mem_dat_o)));

  assert property (@(posedge clk) disable iff (!rst)
    phase == PH_EXEC && op == OP_BEQZ && zero && !block_i |=> pc == $past(branch_target));

endmodule

`default_nettype wire

// File: verif/pico16_mem_model.sv
//--------------------
// word memory for the pico16 testbench, preloaded through a side port
// optional random wait states on block_o while a request is up
//--------------------
`timescale 1ns/1ns
`default_nettype none

module pico16_mem_model
  import pico16_pkg::*;
(
  input  logic              clk,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [WORD_W-1:0] adr_i,
  input  logic [WORD_W-1:0] dat_i,
  output logic [WORD_W-1:0] dat_o,
  output logic              block_o,
  input  logic              blk_en_i,
  input  logic              load_en_i,
  input  logic [7:0]        load_adr_i,
  input  logic [WORD_W-1:0] load_dat_i
);

  logic [WORD_W-1:0] mem [256];

  initial block_o = 1'b0;

  // asynchronous read, shared by fetch and load data
  assign dat_o = mem[adr_i[7:0]];

  always @(posedge clk)
  begin
    if (load_en_i)
      mem[load_adr_i] <= load_dat_i;
    else if (req_i && we_i && !block_o)
      mem[adr_i[7:0]] <= dat_i;
  end

  // wait states change a little after the edge, like other inputs
  always @(posedge clk)
  begin
    #1;
    block_o = blk_en_i && req_i && (($urandom % 3) == 0);
  end

endmodule

`default_nettype wire

// File: verif/pico16_tb.sv
//--------------------
// table-driven program runs for pico16_core
// each row preloads memory, resets and checks the bus writes and acks
//--------------------
`timescale 1ns/1ns
`default_nettype none

module pico16_tb
  import pico16_pkg::*;
;

  localparam int NROWS   = 7;
  localparam int MAXWR   = 8;
  localparam int TIMEOUT = 600;

  logic              clk;
  logic              rst;
  logic              intr;
  logic              nmi;
  logic              block;
  logic              blk_en;
  logic              load_en;
  logic [7:0]        load_adr;
  logic [WORD_W-1:0] load_dat;
  logic [WORD_W-1:0] mem_rdat;
  logic [WORD_W-1:0] mem_adr;
  logic [WORD_W-1:0] mem_wdat;
  logic              mem_we;
  logic              mem_req;
  logic              inta;
  logic              nmia;

  // one row of stimulus and expected values per program run
  logic [WORD_W-1:0] prog [NROWS][64];
  logic [WORD_W-1:0] exp_adr [NROWS][MAXWR];
  logic [WORD_W-1:0] exp_dat [NROWS][MAXWR];
  int                exp_cnt [NROWS];
  int                exp_inta [NROWS];
  int                exp_nmia [NROWS];
  int                intr_cyc [NROWS];
  int                intr_len [NROWS];
  int                nmi_cyc [NROWS];
  int                nmi_len [NROWS];
  int                halt_chk [NROWS];
  logic              row_blk [NROWS];

  int row;
  int cyc;
  int wr_cnt;
  int inta_cnt;
  int nmia_cnt;

  pico16_core uut (
    .clk(clk), .rst(rst), .mem_dat_i(mem_rdat), .block_i(block), .intr_i(intr),
    .nmi_i(nmi), .mem_adr_o(mem_adr), .mem_dat_o(mem_wdat), .mem_we_o(mem_we),
    .mem_req_o(mem_req), .inta_o(inta), .nmia_o(nmia)
  );

  pico16_mem_model u_mem (
    .clk(clk), .req_i(mem_req), .we_i(mem_we), .adr_i(mem_adr), .dat_i(mem_wdat),
    .dat_o(mem_rdat), .block_o(block), .blk_en_i(blk_en), .load_en_i(load_en),
    .load_adr_i(load_adr), .load_dat_i(load_dat)
  );

  always #20 clk = ~clk;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_write(input string what, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
    if (got !== exp)
      fail_now($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_ack(input string what, input int got, input int exp);
    if (got != exp)
      fail_now($sformatf("Mismatch at %0t: %s count %0d expected %0d",
                         $time, what, got, exp));
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp)
      fail_now($sformatf("Mismatch at %0t: %s is %b expected %b", $time, what, got, exp));
  endtask

  function automatic logic [WORD_W-1:0] enc(input opcode_e op, input int rd,
                                            input int rs, input int imm);
    enc = {op, 3'(rd), 3'(rs), 6'(imm)};
  endfunction

  task automatic expect_wr(input int r, input logic [WORD_W-1:0] a,
                           input logic [WORD_W-1:0] d);
    exp_adr[r][exp_cnt[r]] = a;
    exp_dat[r][exp_cnt[r]] = d;
    exp_cnt[r]++;
  endtask

  // r7 = 0x30 is the store base in every program
  task automatic put_base(input int r);
    prog[r][0] = enc(OP_LDI, 7, 0, 24);
    prog[r][1] = enc(OP_ADD, 7, 7, 0);
  endtask

  task automatic build_table();
    for (int r = 0; r < NROWS; r++)
    begin
      for (int a = 0; a < 64; a++)
        prog[r][a] = {4'hE, 4'h0, 8'(a)};
      exp_cnt[r] = 0;
      exp_inta[r] = 0;
      exp_nmia[r] = 0;
      intr_cyc[r] = 0;
      intr_len[r] = 0;
      nmi_cyc[r] = 0;
      nmi_len[r] = 0;
      halt_chk[r] = -1;
      row_blk[r] = 1'b0;
      put_base(r);
    end
    // alu ops
    prog[0][2]  = enc(OP_LDI, 1, 0, 13);
    prog[0][3]  = enc(OP_LDI, 2, 0, -7);
    prog[0][4]  = enc(OP_ADD, 1, 2, 0);
    prog[0][5]  = enc(OP_ST, 1, 7, 0);
    prog[0][6]  = enc(OP_LDI, 3, 0, 5);
    prog[0][7]  = enc(OP_SUB, 3, 2, 0);
    prog[0][8]  = enc(OP_ST, 3, 7, 1);
    prog[0][9]  = enc(OP_LDI, 4, 0, -1);
    prog[0][10] = enc(OP_AND, 4, 2, 0);
    prog[0][11] = enc(OP_ST, 4, 7, 2);
    prog[0][12] = enc(OP_LDI, 5, 0, 21);
    prog[0][13] = enc(OP_XOR, 5, 2, 0);
    prog[0][14] = enc(OP_ST, 5, 7, 3);
    prog[0][15] = enc(OP_LDI, 6, 0, 3);
    prog[0][16] = enc(OP_SUB, 0, 6, 0);
    prog[0][17] = enc(OP_ST, 0, 7, 4);
    prog[0][18] = enc(OP_HLT, 0, 0, 0);
    expect_wr(0, 16'h0030, 16'(13 - 7));
    expect_wr(0, 16'h0031, 16'(5 + 7));
    expect_wr(0, 16'h0032, 16'hFFFF & 16'hFFF9);
    expect_wr(0, 16'h0033, 16'h0015 ^ 16'hFFF9);
    expect_wr(0, 16'h0034, 16'(0 - 3));
    // row 2 repeats the load/store program of row 1 with wait states
    for (int r = 1; r <= 2; r++)
    begin
      prog[r][2]    = enc(OP_LD, 1, 7, 8);
      prog[r][3]    = enc(OP_LD, 2, 7, 9);
      prog[r][4]    = enc(OP_ADD, 1, 2, 0);
      prog[r][5]    = enc(OP_ST, 1, 7, 0);
      prog[r][6]    = enc(OP_LDI, 6, 0, 31);
      prog[r][7]    = enc(OP_ADD, 6, 6, 0);
      prog[r][8]    = enc(OP_LD, 3, 6, -5);
      prog[r][9]    = enc(OP_ST, 3, 6, -12);
      prog[r][10]   = enc(OP_ST, 2, 7, 1);
      prog[r][11]   = enc(OP_HLT, 0, 0, 0);
      prog[r][6'h38] = 16'h1234;
      prog[r][6'h39] = 16'h0F0F;
      expect_wr(r, 16'h0030, 16'h1234 + 16'h0F0F);
      expect_wr(r, 16'h0032, 16'h0F0F);
      expect_wr(r, 16'h0031, 16'h0F0F);
    end
    row_blk[2] = 1'b1;
    // the skipped branch paths would store to 0x30 and 0x33
    prog[3][2]  = enc(OP_LDI, 1, 0, 0);
    prog[3][3]  = enc(OP_BEQZ, 1, 0, 1);
    prog[3][4]  = enc(OP_ST, 7, 7, 0);
    prog[3][5]  = enc(OP_LDI, 2, 0, 5);
    prog[3][6]  = enc(OP_ST, 2, 7, 1);
    prog[3][7]  = enc(OP_BEQZ, 2, 0, 1);
    prog[3][8]  = enc(OP_ST, 2, 7, 2);
    prog[3][9]  = enc(OP_JMP, 0, 0, 12);
    prog[3][10] = enc(OP_ST, 7, 7, 3);
    prog[3][11] = enc(OP_ST, 7, 7, 3);
    prog[3][12] = enc(OP_LDI, 3, 0, -3);
    prog[3][13] = enc(OP_ST, 3, 7, 4);
    prog[3][14] = enc(OP_HLT, 0, 0, 0);
    expect_wr(3, 16'h0031, 16'd5);
    expect_wr(3, 16'h0032, 16'd5);
    expect_wr(3, 16'h0034, 16'(0 - 3));
    // halt woken by intr
    prog[4][2]  = enc(OP_EI, 0, 0, 0);
    prog[4][3]  = enc(OP_HLT, 0, 0, 0);
    prog[4][4]  = enc(OP_LDI, 1, 0, 7);
    prog[4][5]  = enc(OP_ST, 1, 7, 1);
    prog[4][6]  = enc(OP_HLT, 0, 0, 0);
    prog[4][16] = enc(OP_LDI, 2, 0, 9);
    prog[4][17] = enc(OP_ST, 2, 7, 0);
    prog[4][18] = enc(OP_IRET, 0, 0, 0);
    expect_wr(4, 16'h0030, 16'd9);
    expect_wr(4, 16'h0031, 16'd7);
    exp_inta[4] = 1;
    intr_cyc[4] = 20;
    intr_len[4] = 1;
    halt_chk[4] = 18;
    // enabled and then masked again, so intr never reaches the handler store at 0x3f
    prog[5][2]  = enc(OP_EI, 0, 0, 0);
    prog[5][3]  = enc(OP_DI, 0, 0, 0);
    prog[5][4]  = enc(OP_LDI, 1, 0, 3);
    prog[5][5]  = enc(OP_ST, 1, 7, 0);
    prog[5][6]  = enc(OP_HLT, 0, 0, 0);
    prog[5][16] = enc(OP_LDI, 2, 0, 1);
    prog[5][17] = enc(OP_ST, 2, 7, 15);
    prog[5][18] = enc(OP_IRET, 0, 0, 0);
    expect_wr(5, 16'h0030, 16'd3);
    intr_cyc[5] = 18;
    intr_len[5] = 4;
    // nmi level held high with interrupts disabled
    prog[6][2]  = enc(OP_DI, 0, 0, 0);
    prog[6][3]  = enc(OP_HLT, 0, 0, 0);
    prog[6][4]  = enc(OP_LDI, 1, 0, 4);
    prog[6][5]  = enc(OP_ST, 1, 7, 1);
    prog[6][6]  = enc(OP_HLT, 0, 0, 0);
    prog[6][32] = enc(OP_LDI, 2, 0, 6);
    prog[6][33] = enc(OP_ST, 2, 7, 2);
    prog[6][34] = enc(OP_IRET, 0, 0, 0);
    expect_wr(6, 16'h0032, 16'd6);
    expect_wr(6, 16'h0031, 16'd4);
    exp_nmia[6] = 1;
    nmi_cyc[6] = 20;
    nmi_len[6] = 6;
    halt_chk[6] = 18;
  endtask

  // bus writes and acks are sampled before the edge updates them
  always @(posedge clk)
  begin
    if (rst === 1'b1)
    begin
      if (mem_req && mem_we && !block)
      begin
        if (wr_cnt >= exp_cnt[row])
          fail_now($sformatf("Mismatch at %0t: unexpected write of %h to %h",
                             $time, mem_wdat, mem_adr));
        else
        begin
          check_write("write address", mem_adr, exp_adr[row][wr_cnt]);
          check_write("write data", mem_wdat, exp_dat[row][wr_cnt]);
          wr_cnt++;
        end
      end
      if (inta)
        inta_cnt++;
      if (nmia)
        nmia_cnt++;
    end
  end

  task automatic step_cycle();
    @(posedge clk);
    #1;
    cyc++;
    intr = (cyc >= intr_cyc[row]) && (cyc < intr_cyc[row] + intr_len[row]);
    nmi  = (cyc >= nmi_cyc[row]) && (cyc < nmi_cyc[row] + nmi_len[row]);
    if (cyc == halt_chk[row])
      check_level("mem_req_o in halt", mem_req, 1'b0);
  endtask

  task automatic run_row(input int r);
    int waited;
    row = r;
    rst = 1'b0;
    blk_en = 1'b0;
    wr_cnt = 0;
    inta_cnt = 0;
    nmia_cnt = 0;
    for (int a = 0; a < 256; a++)
    begin
      @(posedge clk);
      #1;
      load_en = 1'b1;
      load_adr = 8'(a);
      load_dat = (a < 64) ? prog[r][a] : {4'hE, 4'h0, 8'(a)};
    end
    @(posedge clk);
    #1;
    load_en = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    blk_en = row_blk[r];
    rst = 1'b1;
    cyc = 0;
    waited = 0;
    while (wr_cnt < exp_cnt[r])
    begin
      step_cycle();
      waited++;
      if (waited > TIMEOUT)
        fail_now($sformatf("row %0d timed out waiting for bus write %0d", r, wr_cnt));
    end
    // no further writes or acks may show up in the quiet tail
    waited = 0;
    while (waited < 40)
    begin
      step_cycle();
      waited++;
    end
    check_ack("inta_o", inta_cnt, exp_inta[r]);
    check_ack("nmia_o", nmia_cnt, exp_nmia[r]);
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b0;
    intr = 1'b0;
    nmi = 1'b0;
    blk_en = 1'b0;
    load_en = 1'b0;
    load_adr = '0;
    load_dat = '0;
    row = 0;
    cyc = 0;
    wr_cnt = 0;
    inta_cnt = 0;
    nmia_cnt = 0;
    void'($urandom(4977));
    build_table();
    for (int r = 0; r < NROWS; r++)
      run_row(r);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: pico16_core.f
src/pico16_pkg.sv
src/pico16_fetch.sv
src/pico16_decode.sv
src/pico16_execute.sv
src/pico16_result.sv
src/pico16_irq.sv
src/pico16_core.sv
verif/pico16_mem_model.sv
verif/pico16_tb.sv

// File: Makefile
# Verilator flow for the pico16 core

FLIST = pico16_core.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -sv -f $(FLIST) --top-module pico16_tb
	verilator --lint-only --timing --assert -sv -f $(FLIST) --top-module pico16_core

sim:
	verilator --binary --timing --assert -sv -f $(FLIST) --top-module pico16_tb \
		-o Vpico16_tb
	./obj_dir/Vpico16_tb > sim.log 2>&1 || true
	cat sim.log
	grep -F -q "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
